// File: build.f
hw/masked_add_pkg.sv
hw/dom_and.sv
hw/delay_masked_shares.sv
hw/ks_prefix_level.sv
hw/masked_adder.sv
dv/masked_adder_assert.sv
dv/masked_adder_tb.sv

// File: dv/masked_adder_assert.sv
/* Concurrent checks on valid latency, zeroize and reset of the masked adder.
   Attached to the DUT with bind from the testbench. */

`timescale 1ns/1ps

module masked_adder_assert import masked_add_pkg::*; (
    input wire       clk,
    input wire       rst_n,
    input wire       zeroize,
    input wire       in_valid,
    input wire       out_valid,
    input wire [1:0] sum_shares [ADD_W-1:0]
);

    // Share vectors flattened for the properties
    logic [ADD_W-1:0] sum_s0;
    logic [ADD_W-1:0] sum_s1;

    always_comb begin
        for (int i = 0; i < ADD_W; i++) begin
            sum_s0[i] = sum_shares[i][0];
            sum_s1[i] = sum_shares[i][1];
        end
    end

    // Clear events of the last LATENCY edges, bit 0 is the latest
    logic [LATENCY-1:0] clear_hist;

    always_ff @(posedge clk) begin
        clear_hist <= {clear_hist[LATENCY-2:0], zeroize || !rst_n};
    end

    // An accepted item shows up exactly LATENCY edges later unless it was wiped
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == ($past(in_valid, LATENCY) && !(|clear_hist)))
        else $error("out_valid does not follow in_valid by the pipeline latency");

    a_zeroize: assert property (@(posedge clk)
        zeroize |=> (!out_valid && sum_s0 == '0 && sum_s1 == '0))
        else $error("outputs not cleared one cycle after zeroize");

    a_reset: assert property (@(posedge clk)
        !rst_n |=> (!out_valid && sum_s0 == '0 && sum_s1 == '0))
        else $error("outputs not cleared during reset");

endmodule

// File: dv/masked_adder_tb.sv
/* Testbench for the masked adder. Streams share pairs from the vector file,
   unmasks every result and compares it with the expected sum. */

`timescale 1ns/1ps

module masked_adder_tb import masked_add_pkg::*; ();

    localparam string TEST_FILE = "dv/masked_adder_tests.txt";

    logic             clk = 1'b0;
    logic             rst_n;
    logic             zeroize;
    logic             in_valid;
    logic [1:0]       a_shares [ADD_W-1:0];
    logic [1:0]       b_shares [ADD_W-1:0];
    logic [RND_W-1:0] rnd;
    logic             out_valid;
    logic [1:0]       sum_shares [ADD_W-1:0];

    // Parsed file lines, kind 0 vector, 1 zeroize, 2 gap
    int                 cmd_kind [$];
    int                 cmd_gap [$];
    logic [5*ADD_W-1:0] cmd_vec [$];
    // Pending results, due cycle and expected unmasked sum
    int                 due_q [$];
    logic [ADD_W-1:0]   exp_q [$];

    int     tick = 0;
    int     cycles = 0;
    int     limit = 1000;
    int     errors = 0;
    int     tests = 0;
    int     failed = 0;
    int     dropped = 0;
    int     line_count = 0;
    int     gap_total = 0;
    integer seed = 32'h1396094c;
    logic [((RND_W + 31) / 32) * 32 - 1:0] rnd_pool;

    masked_adder masked_adder_i (.*);

    bind masked_adder masked_adder_assert u_assert (
        .clk(clk), .rst_n(rst_n), .zeroize(zeroize), .in_valid(in_valid),
        .out_valid(out_valid), .sum_shares(sum_shares)
    );

    always #20 clk = ~clk;

    // Run limit, derived from the file length once it is read
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, the test sequence did not finish", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic read_tests();
        int               fd;
        int               n;
        byte              c;
        string            line;
        logic [ADD_W-1:0] a0;
        logic [ADD_W-1:0] a1;
        logic [ADD_W-1:0] b0;
        logic [ADD_W-1:0] b1;
        logic [ADD_W-1:0] sum_exp;
        logic [ADD_W-1:0] sum_rule;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the vector file %s", TEST_FILE);
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                c = (line.len() > 0) ? line.getc(0) : "#";
                if (c != "#" && c != "\n") begin
                    line_count++;
                    n = 0;
                    if (c == "Z") begin
                        cmd_kind.push_back(1);
                    end else if (c == "G") begin
                        void'($sscanf(line, "G %d", n));
                        gap_total += n;
                        cmd_kind.push_back(2);
                    end else if ($sscanf(line, "%h %h %h %h %h",
                                         a0, a1, b0, b1, sum_exp) == 5) begin
                        // Expected column must agree with the modular sum of the unmasked operands
                        sum_rule = (a0 ^ a1) + (b0 ^ b1);
                        check_value("file expected_sum", 32'(sum_exp), 32'(sum_rule));
                        cmd_kind.push_back(0);
                    end else begin
                        $display("unreadable line in the vector file: %s", line);
                        errors++;
                        cmd_kind.push_back(2);
                    end
                    cmd_gap.push_back(n);
                    cmd_vec.push_back({a0, a1, b0, b1, sum_exp});
                end
            end
            $fclose(fd);
        end
    endtask

    // Outputs are stable at the falling edge, half a cycle after they change
    task automatic check_outputs();
        logic [ADD_W-1:0] s0;
        logic [ADD_W-1:0] s1;
        int               err_before;
        for (int i = 0; i < ADD_W; i++) begin
            s0[i] = sum_shares[i][0];
            s1[i] = sum_shares[i][1];
        end
        if (!rst_n) begin
            check_value("sum_shares share 0", 32'(s0), 32'h0);
            check_value("sum_shares share 1", 32'(s1), 32'h0);
        end
        if (due_q.size() > 0 && due_q[0] == tick) begin
            err_before = errors;
            check_value("out_valid", 32'(out_valid), 32'h1);
            check_value("sum", 32'(s0 ^ s1), 32'(exp_q[0]));
            tests++;
            if (errors != err_before) begin
                failed++;
            end
            $display("test %0d: expected %h, got %h, %s", tests, exp_q[0], s0 ^ s1,
                     (errors == err_before) ? "ok" : "FAIL");
            void'(due_q.pop_front());
            void'(exp_q.pop_front());
        end else begin
            check_value("out_valid", 32'(out_valid), 32'h0);
        end
    endtask

    // One cycle: check, then idle drive with fresh randomness
    task automatic next_cycle();
        @(negedge clk);
        tick++;
        check_outputs();
        in_valid = 1'b0;
        zeroize = 1'b0;
        for (int k = 0; k < $bits(rnd_pool) / 32; k++) begin
            rnd_pool[k*32 +: 32] = $random(seed);
        end
        rnd = rnd_pool[RND_W-1:0];
    endtask

    task automatic drive_vector(input logic [5*ADD_W-1:0] vec);
        logic [ADD_W-1:0] a0;
        logic [ADD_W-1:0] a1;
        logic [ADD_W-1:0] b0;
        logic [ADD_W-1:0] b1;
        logic [ADD_W-1:0] sum_exp;
        {a0, a1, b0, b1, sum_exp} = vec;
        for (int i = 0; i < ADD_W; i++) begin
            a_shares[i] = {a1[i], a0[i]};
            b_shares[i] = {b1[i], b0[i]};
        end
        in_valid = 1'b1;
        due_q.push_back(tick + LATENCY);
        exp_q.push_back(sum_exp);
    endtask

    initial begin
        rst_n = 1'b0;
        zeroize = 1'b0;
        in_valid = 1'b0;
        rnd = '0;
        for (int i = 0; i < ADD_W; i++) begin
            a_shares[i] = 2'b00;
            b_shares[i] = 2'b00;
        end
        read_tests();
        limit = (line_count + LATENCY + gap_total) * 2 + 100;
        repeat (10) next_cycle();
        rst_n = 1'b1;
        for (int j = 0; j < cmd_kind.size(); j++) begin
            next_cycle();
            if (cmd_kind[j] == 0) begin
                drive_vector(cmd_vec[j]);
            end else if (cmd_kind[j] == 1) begin
                // Everything still pending is wiped and must never appear
                zeroize = 1'b1;
                $display("zeroize: %0d vectors in flight dropped", due_q.size());
                dropped += due_q.size();
                due_q.delete();
                exp_q.delete();
            end else begin
                repeat (cmd_gap[j] - 1) next_cycle();
            end
        end
        repeat (LATENCY + 2) next_cycle();
        $display("%0d tests, %0d failed, %0d dropped by zeroize, %0d errors",
                 tests, failed, dropped, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: dv/masked_adder_tests.txt
# a0 a1 b0 b1 expected_sum in hex; operands are a0^a1 and b0^b1, sum mod 2^16
# Z = zeroize for one cycle, G n = n idle cycles
1234 0000 1111 0000 2345
A5A5 5A5A 0F0F 0F0E 0000
8000 0000 C000 4000 0000
AAAA 0000 5555 0000 FFFF
F0F0 A5A5 5555 0000 AAAA
0000 AAAA FFFF 5555 5554
FFFF 0000 1234 EDCB FFFE
FFFF EDCB 0F0F 1E1E 2345
B9F9 ABCD 2D2D 3C3C 2345
G 8
0001 0000 7FFF 0000 8000
G 3
00FF 0000 0001 0000 0100
G 10
4321 0000 1000 0000 5321
0F00 F000 0100 0000 0000
7FFF 0000 7FFF 0000 FFFE
Z
0000 0000 0000 0000 0000
FFFF FFFF 0001 0000 0001
3C3C C3C3 0101 0000 0100
G 2
8001 0000 7FFF 0000 0000
1111 2222 4444 8888 FFFF

// File: hw/delay_masked_shares.sv
/* Zeroizable shift register for a vector of share pairs.
   Delays every pair by N cycles; reset or zeroize clears all stages. */

`timescale 1ns/1ps

module delay_masked_shares import masked_add_pkg::*; #(
    // Number of share pairs carried
    parameter int WIDTH = ADD_W,
    // Delay in cycles, at least 1
    parameter int N = 1
) (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        zeroize,
    input  wire [1:0]  input_reg [WIDTH-1:0],
    output logic [1:0] delayed_reg [WIDTH-1:0]
);

    // Stage 0 takes the input, stage N-1 drives the output
    logic [1:0] stage_q [N-1:0][WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            // Wipe every item in flight
            for (int s = 0; s < N; s++) begin
                for (int i = 0; i < WIDTH; i++) begin
                    stage_q[s][i] <= 2'b00;
                end
            end
        end else begin
            // Advance the older stages first in index order
            for (int s = N - 1; s > 0; s--) begin
                for (int i = 0; i < WIDTH; i++) begin
                    stage_q[s][i] <= stage_q[s-1][i];
                end
            end
            for (int i = 0; i < WIDTH; i++) begin
                stage_q[0][i] <= input_reg[i];
            end
        end
    end

    // Output is the oldest stage
    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            delayed_reg[i] = stage_q[N-1][i];
        end
    end

endmodule

// File: hw/dom_and.sv
/* Vector of first-order DOM AND gates, one fresh random bit per gate.
   Result shares appear one cycle after the operands are sampled. */

`timescale 1ns/1ps

module dom_and import masked_add_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             zeroize,
    input  wire [1:0]       x [ADD_W-1:0],
    input  wire [1:0]       y [ADD_W-1:0],
    input  wire [ADD_W-1:0] r,
    output logic [1:0]      z [ADD_W-1:0]
);

    // Registered inner-domain and refreshed cross-domain terms
    logic [ADD_W-1:0] inner0_q;
    logic [ADD_W-1:0] inner1_q;
    logic [ADD_W-1:0] cross01_q;
    logic [ADD_W-1:0] cross10_q;

    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            inner0_q  <= '0;
            inner1_q  <= '0;
            cross01_q <= '0;
            cross10_q <= '0;
        end else begin
            for (int i = 0; i < ADD_W; i++) begin
                inner0_q[i]  <= x[i][0] & y[i][0];
                inner1_q[i]  <= x[i][1] & y[i][1];
                // Cross terms masked by the same bit, cancels in the unmasked sum
                cross01_q[i] <= (x[i][0] & y[i][1]) ^ r[i];
                cross10_q[i] <= (x[i][1] & y[i][0]) ^ r[i];
            end
        end
    end

    // Domain compression only after the register stage
    always_comb begin
        for (int i = 0; i < ADD_W; i++) begin
            z[i][0] = inner0_q[i] ^ cross01_q[i];
            z[i][1] = inner1_q[i] ^ cross10_q[i];
        end
    end

endmodule

// File: hw/ks_prefix_level.sv
/* One masked Kogge-Stone prefix level at distance DIST.
   Combines generate/propagate share pairs with a latency of one cycle. */

`timescale 1ns/1ps

module ks_prefix_level import masked_add_pkg::*; #(
    // Span to the lower group, 1, 2, 4 or 8
    parameter int DIST = 1
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 zeroize,
    input  wire [1:0]           g_in  [ADD_W-1:0],
    input  wire [1:0]           p_in  [ADD_W-1:0],
    input  wire [RND_LVL_W-1:0] r,
    output logic [1:0]          g_out [ADD_W-1:0],
    output logic [1:0]          p_out [ADD_W-1:0]
);

    // ==================================================
    // Operands from the group DIST bits below
    // ==================================================

    logic [1:0] g_low [ADD_W-1:0];
    logic [1:0] p_low [ADD_W-1:0];

    // Bits below DIST already reach bit 0, so they see a zero group
    for (genvar i = 0; i < ADD_W; i++) begin : g_sel
        if (i >= DIST) begin : g_upper
            assign g_low[i] = g_in[i-DIST];
            assign p_low[i] = p_in[i-DIST];
        end else begin : g_lower
            assign g_low[i] = 2'b00;
            assign p_low[i] = 2'b00;
        end
    end

    // ==================================================
    // Masked AND layer
    // ==================================================

    // p_i & G_low, the carry generated in the lower group
    logic [1:0] pg [ADD_W-1:0];

    dom_and u_and_g (
        .clk     (clk),
        .rst_n   (rst_n),
        .zeroize (zeroize),
        .x       (p_in),
        .y       (g_low),
        .r       (r[ADD_W-1:0]),
        .z       (pg)
    );

    // p_i & P_low becomes the new group propagate directly
    dom_and u_and_p (
        .clk     (clk),
        .rst_n   (rst_n),
        .zeroize (zeroize),
        .x       (p_in),
        .y       (p_low),
        .r       (r[RND_LVL_W-1:ADD_W]),
        .z       (p_out)
    );

    // Linear term waits one cycle to meet the AND result
    logic [1:0] g_dly [ADD_W-1:0];

    delay_masked_shares #(
        .WIDTH (ADD_W),
        .N     (1)
    ) u_g_dly (
        .clk         (clk),
        .rst_n       (rst_n),
        .zeroize     (zeroize),
        .input_reg   (g_in),
        .delayed_reg (g_dly)
    );

    // G and P of one group are exclusive, so the OR reduces to XOR per domain
    always_comb begin
        for (int i = 0; i < ADD_W; i++) begin
            g_out[i] = g_dly[i] ^ pg[i];
        end
    end

endmodule

// File: hw/masked_add_pkg.sv
/* Shared sizes for the first-order masked Kogge-Stone adder.
   Imported by wildcard into every RTL module of the adder. */

package masked_add_pkg;

    // ==================================================
    // Data path geometry
    // ==================================================

    // Operand and sum width, one share pair per bit
    localparam int ADD_W = 16;

    // Prefix levels of the Kogge-Stone tree, log2 of ADD_W
    localparam int LEVELS = 4;

    // Generate stage, one cycle per level, then the sum register
    localparam int LATENCY = 1 + LEVELS + 1;

    // ==================================================
    // Randomness budget per cycle
    // ==================================================

    // One fresh bit per DOM AND in the generate stage
    localparam int RND_GEN_W = ADD_W;

    // Two ANDs per bit in every prefix level (generate and propagate)
    localparam int RND_LVL_W = 2 * ADD_W;

    // Whole random word consumed each cycle
    localparam int RND_W = RND_GEN_W + LEVELS * RND_LVL_W;

endpackage

// File: hw/masked_adder.sv
/* Top of the first-order masked 16-bit adder, Boolean shares in and out.
   Accepts one operand pair per cycle; the sum follows LATENCY cycles later. */

`timescale 1ns/1ps

module masked_adder import masked_add_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             zeroize,
    input  wire             in_valid,
    input  wire [1:0]       a_shares [ADD_W-1:0],
    input  wire [1:0]       b_shares [ADD_W-1:0],
    input  wire [RND_W-1:0] rnd,
    output logic            out_valid,
    output logic [1:0]      sum_shares [ADD_W-1:0]
);

    // ==================================================
    // Generate stage
    // ==================================================

    // Index k is the input of prefix level k, LEVELS is the tree output
    logic [1:0] g_stage [LEVELS:0][ADD_W-1:0];
    logic [1:0] p_stage [LEVELS:0][ADD_W-1:0];

    // Bitwise propagate, linear so each share is handled on its own
    logic [1:0] p_raw [ADD_W-1:0];

    always_comb begin
        for (int i = 0; i < ADD_W; i++) begin
            p_raw[i] = a_shares[i] ^ b_shares[i];
        end
    end

    dom_and u_gen_and (
        .clk     (clk),
        .rst_n   (rst_n),
        .zeroize (zeroize),
        .x       (a_shares),
        .y       (b_shares),
        .r       (rnd[RND_GEN_W-1:0]),
        .z       (g_stage[0])
    );

    // Align p with the registered generate terms
    delay_masked_shares #(.WIDTH(ADD_W), .N(1)) u_p_gen_dly (
        .clk         (clk),
        .rst_n       (rst_n),
        .zeroize     (zeroize),
        .input_reg   (p_raw),
        .delayed_reg (p_stage[0])
    );

    // ==================================================
    // Prefix tree, distances 1, 2, 4, 8
    // ==================================================

    for (genvar k = 0; k < LEVELS; k++) begin : g_level
        ks_prefix_level #(.DIST(1 << k)) u_level (
            .clk     (clk),
            .rst_n   (rst_n),
            .zeroize (zeroize),
            .g_in    (g_stage[k]),
            .p_in    (p_stage[k]),
            .r       (rnd[RND_GEN_W + k*RND_LVL_W +: RND_LVL_W]),
            .g_out   (g_stage[k+1]),
            .p_out   (p_stage[k+1])
        );
    end

    // Original propagate held until the final carries are ready
    logic [1:0] p_final [ADD_W-1:0];

    delay_masked_shares #(.WIDTH(ADD_W), .N(LEVELS + 1)) u_p_sum_dly (
        .clk         (clk),
        .rst_n       (rst_n),
        .zeroize     (zeroize),
        .input_reg   (p_raw),
        .delayed_reg (p_final)
    );

    // ==================================================
    // Sum register and valid pipeline
    // ==================================================

    // Carry into bit i is the group generate of bits i-1 down to 0
    logic [1:0] carry [ADD_W-1:0];

    always_comb begin
        carry[0] = 2'b00;
        for (int i = 1; i < ADD_W; i++) begin
            carry[i] = g_stage[LEVELS][i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || zeroize) begin
            for (int i = 0; i < ADD_W; i++) begin
                sum_shares[i] <= 2'b00;
            end
        end else begin
            for (int i = 0; i < ADD_W; i++) begin
                sum_shares[i] <= p_final[i] ^ carry[i];
            end
        end
    end

    // Valid rides as a trivially shared bit, share 1 fixed at zero
    logic [1:0] valid_in  [0:0];
    logic [1:0] valid_out [0:0];

    assign valid_in[0] = {1'b0, in_valid};

    delay_masked_shares #(.WIDTH(1), .N(LATENCY)) u_valid_dly (
        .clk         (clk),
        .rst_n       (rst_n),
        .zeroize     (zeroize),
        .input_reg   (valid_in),
        .delayed_reg (valid_out)
    );

    assign out_valid = valid_out[0][0] ^ valid_out[0][1];

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the masked adder testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module masked_adder_tb \
    -f build.f \
    -Mdir obj_dir

./obj_dir/Vmasked_adder_tb 2>&1 | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
